//--- src/vic_defs.svh
`ifndef VIC_DEFS_SVH
`define VIC_DEFS_SVH

// shared sizing for the fetch back end

// hardware sprites, sprite 0 has top priority
`define VIC_NUM_SPRITES 8

// character pointers fetched per text line
// buffer counter wraps after the last one
`define VIC_CHAR_LINE_LEN 40

// line buffer entries
// power of two above the line length so the counter is a plain binary index
`define VIC_CHAR_BUF_DEPTH 64

`endif

//--- src/vic_cycle_pkg.sv
package vic_cycle_pkg;

    // kind of bus cycle the sequencer presents on this half cycle
    // encoding follows the chip's cycle numbering, gaps are cycle kinds
    // with no data bus read (sprite idle, refresh variants)
    typedef enum logic [3:0] {
        // sprite pointer fetch
        cycle_lp  = 4'd0,
        // second sprite data byte
        cycle_ls2 = 4'd2,
        // dram refresh, nothing sampled
        cycle_lr  = 4'd3,
        // graphics fetch
        cycle_lg  = 4'd4,
        // first sprite data byte
        cycle_hs1 = 4'd5,
        // third sprite data byte
        cycle_hs3 = 4'd8,
        // badline c-access during refresh slot
        cycle_hrc = 4'd10,
        // badline c-access during graphics slot
        cycle_hgc = 4'd11,
        // replayed c-access, graphics slot
        cycle_hgi = 4'd12,
        // idle access
        cycle_li  = 4'd14,
        // replayed c-access, refresh slot
        cycle_hrx = 4'd15
    } cycle_type_e;

endpackage

//--- src/vic_data_pkg.sv
`include "vic_defs.svh"

package vic_data_pkg;

    // one c-access result as it sits on the 12 bit bus
    // colour nibble on the upper lines, code byte below
    typedef struct packed {
        logic [3:0] colour;
        logic [7:0] code;
    } char_word_t;

    // three s-access bytes of one sprite line
    // first byte fetched ends up in the top bits, shifted out first
    typedef struct packed {
        logic [7:0] first;
        logic [7:0] second;
        logic [7:0] third;
    } sprite_word_t;

    // sprite number, wide enough for all sprites
    typedef logic [$clog2(`VIC_NUM_SPRITES)-1:0] sprite_idx_t;

    // winning sprite for the current pixel
    // index is only meaningful with hit set
    typedef struct packed {
        logic        hit;
        sprite_idx_t index;
    } sprite_pixel_t;

endpackage

//--- src/vic_bus_access.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module vic_bus_access (
    input  logic                              clk_dot4x,
    input  logic                              rst,
    input  logic                              phi_phase_start_dav,
    input  logic                              idle,
    input  logic                              aec,
    input  vic_cycle_pkg::cycle_type_e        cycle_type,
    input  vic_data_pkg::char_word_t          dbi,
    input  logic [2:0]                        sprite_cnt,
    input  logic [`VIC_NUM_SPRITES-1:0]       sprite_dma,
    output logic [7:0]                        sprite_ptr [`VIC_NUM_SPRITES],
    output vic_data_pkg::sprite_word_t        sprite_words [`VIC_NUM_SPRITES],
    output logic [7:0]                        pixels_read,
    output vic_data_pkg::char_word_t          char_read,
    output vic_data_pkg::char_word_t          char_next
);

    // index width of the line buffer
    localparam int BUF_AW = $clog2(`VIC_CHAR_BUF_DEPTH);

    // character line buffer, filled on badlines
    vic_data_pkg::char_word_t char_buf [`VIC_CHAR_BUF_DEPTH];
    logic [BUF_AW-1:0]        char_buf_cnt;

    // word a badline c-access would store
    vic_data_pkg::char_word_t char_fetch;

    // cycle decode
    logic c_badline;
    logic c_replay;
    logic s_access;
    // vic owns the bus while aec is low
    logic vic_bus;

    assign vic_bus = ~aec;

    always_comb begin
        c_badline = 1'b0;
        c_replay  = 1'b0;
        s_access  = 1'b0;
        case (cycle_type)
            // fresh pointer fetch on a badline
            vic_cycle_pkg::cycle_hrc,
            vic_cycle_pkg::cycle_hgc: c_badline = 1'b1;
            // other lines of the row reuse the buffer
            vic_cycle_pkg::cycle_hrx,
            vic_cycle_pkg::cycle_hgi: c_replay = 1'b1;
            // the three sprite data slots
            vic_cycle_pkg::cycle_hs1,
            vic_cycle_pkg::cycle_ls2,
            vic_cycle_pkg::cycle_hs3: s_access = 1'b1;
            default: ;
        endcase
    end

    // colour nibble is always valid on the bus
    // code reads as 0xff unless the vic has the bus
    always_comb begin
        char_fetch.colour = dbi.colour;
        char_fetch.code   = vic_bus ? dbi.code : 8'hff;
    end

    // buffer write port, badline only
    always_ff @(posedge clk_dot4x) begin
        if (phi_phase_start_dav && c_badline) begin
            char_buf[char_buf_cnt] <= char_fetch;
        end
    end

    // c-access: next character word and buffer position
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            char_buf_cnt <= '0;
            char_next    <= '0;
        end else if (phi_phase_start_dav) begin
            if (c_badline) begin
                // same word that goes into the buffer
                char_next <= char_fetch;
            end else if (c_replay) begin
                // replay what the badline stored here
                char_next <= char_buf[char_buf_cnt];
            end
            // every c-access slot moves one position
            if (c_badline || c_replay) begin
                if (char_buf_cnt == BUF_AW'(`VIC_CHAR_LINE_LEN - 1)) begin
                    char_buf_cnt <= '0;
                end else begin
                    char_buf_cnt <= char_buf_cnt + BUF_AW'(1);
                end
            end
        end
    end

    // g-access: graphics byte plus the character it belongs to
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_read <= '0;
            char_read   <= '0;
        end else if (phi_phase_start_dav && vic_bus) begin
            if (cycle_type == vic_cycle_pkg::cycle_lg) begin
                pixels_read <= dbi.code;
                // idle state shows no character data
                char_read   <= idle ? '0 : char_next;
            end else begin
                // nothing fetched this slot
                pixels_read <= '0;
            end
        end
    end

    // p-access: sprite pointer of the current sprite
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < `VIC_NUM_SPRITES; n++) begin
                sprite_ptr[n] <= '0;
            end
        end else if (phi_phase_start_dav && vic_bus &&
                     cycle_type == vic_cycle_pkg::cycle_lp) begin
            // sprite without dma reads open bus as 0xff
            if (sprite_dma[sprite_cnt]) begin
                sprite_ptr[sprite_cnt] <= dbi.code;
            end else begin
                sprite_ptr[sprite_cnt] <= 8'hff;
            end
        end
    end

    // s-access: byte-wise shift into the current sprite word
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < `VIC_NUM_SPRITES; n++) begin
                sprite_words[n] <= '0;
            end
        end else if (phi_phase_start_dav && vic_bus && s_access &&
                     sprite_dma[sprite_cnt]) begin
            // oldest byte drops off the top
            sprite_words[sprite_cnt].first  <= sprite_words[sprite_cnt].second;
            sprite_words[sprite_cnt].second <= sprite_words[sprite_cnt].third;
            sprite_words[sprite_cnt].third  <= dbi.code;
        end
    end

endmodule

//--- src/vic_sprite_shifter.sv
`timescale 1ns/10ps

module vic_sprite_shifter (
    input  logic                       clk_dot4x,
    input  logic                       rst,
    input  logic                       load,
    input  logic                       shift,
    input  vic_data_pkg::sprite_word_t word,
    output logic                       bit_out
);

    // one sprite line, msb is the pixel on screen
    logic [23:0] shift_reg;

    // zeros fill in from the bottom
    // after 24 shifts the sprite is transparent until reloaded
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_reg <= '0;
        end else if (load) begin
            // load wins over a shift in the same cycle
            shift_reg <= word;
        end else if (shift) begin
            shift_reg <= {shift_reg[22:0], 1'b0};
        end
    end

    // current pixel straight from the register
    assign bit_out = shift_reg[23];

endmodule

//--- src/vic_sprite_priority.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module vic_sprite_priority (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  logic [`VIC_NUM_SPRITES-1:0] bits,
    output vic_data_pkg::sprite_pixel_t pixel
);

    // combinational winner for this cycle
    vic_data_pkg::sprite_pixel_t pixel_next;

    // lowest set bit wins, sprite 0 is in front
    // walk from the top so the last hit seen is the lowest
    always_comb begin
        pixel_next.hit   = |bits;
        pixel_next.index = '0;
        for (int i = `VIC_NUM_SPRITES - 1; i >= 0; i--) begin
            if (bits[i]) begin
                pixel_next.index = vic_data_pkg::sprite_idx_t'(i);
            end
        end
    end

    // one cycle after the bit vector
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel <= '0;
        end else begin
            pixel <= pixel_next;
        end
    end

endmodule

//--- src/vic_fetch_top.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module vic_fetch_top (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  logic                        phi_phase_start_dav,
    input  vic_cycle_pkg::cycle_type_e  cycle_type,
    input  vic_data_pkg::char_word_t    dbi,
    input  logic                        idle,
    input  logic                        aec,
    input  logic [2:0]                  sprite_cnt,
    input  logic [`VIC_NUM_SPRITES-1:0] sprite_dma,
    input  logic [`VIC_NUM_SPRITES-1:0] sprite_load,
    input  logic                        pixel_stb,
    output logic [7:0]                  sprite_ptr [`VIC_NUM_SPRITES],
    output logic [7:0]                  pixels_read,
    output vic_data_pkg::char_word_t    char_read,
    output vic_data_pkg::char_word_t    char_next,
    output vic_data_pkg::sprite_pixel_t sprite_pixel
);

    // fetched sprite lines, one per shifter
    vic_data_pkg::sprite_word_t sprite_words [`VIC_NUM_SPRITES];

    // current pixel of every sprite
    logic [`VIC_NUM_SPRITES-1:0] sprite_bits;

    // data bus sampling for all four access kinds
    vic_bus_access vic_bus_access_i (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .phi_phase_start_dav (phi_phase_start_dav),
        .idle                (idle),
        .aec                 (aec),
        .cycle_type          (cycle_type),
        .dbi                 (dbi),
        .sprite_cnt          (sprite_cnt),
        .sprite_dma          (sprite_dma),
        .sprite_ptr          (sprite_ptr),
        .sprite_words        (sprite_words),
        .pixels_read         (pixels_read),
        .char_read           (char_read),
        .char_next           (char_next)
    );

    // one shifter per sprite
    // own load bit, common pixel strobe
    for (genvar s = 0; s < `VIC_NUM_SPRITES; s++) begin : g_sprite
        vic_sprite_shifter vic_sprite_shifter_i (
            .clk_dot4x (clk_dot4x),
            .rst       (rst),
            .load      (sprite_load[s]),
            .shift     (pixel_stb),
            .word      (sprite_words[s]),
            .bit_out   (sprite_bits[s])
        );
    end

    // front-most opaque sprite
    vic_sprite_priority vic_sprite_priority_i (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .bits      (sprite_bits),
        .pixel     (sprite_pixel)
    );

endmodule

//--- tests/tb_vic_fetch.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module tb_vic_fetch;

    localparam time CLK_PERIOD   = 20ns;
    localparam int  RESET_CYCLES = 16;
    // input skew after the rising edge
    localparam time DRIVE_DELAY  = 2ns;
    // sprites 0, 2, 5 and 7 have dma
    localparam logic [`VIC_NUM_SPRITES-1:0] SPRITE_DMA = 8'b1010_0101;

    // one table row applied for reps cycles in a row
    typedef struct packed {
        vic_cycle_pkg::cycle_type_e  ctype;
        logic                        dav;
        logic                        aec;
        logic                        idle;
        logic [2:0]                  cnt;
        logic [`VIC_NUM_SPRITES-1:0] dma;
        logic [`VIC_NUM_SPRITES-1:0] load;
        logic                        pix;
        logic                        rnd;
        logic [11:0]                 dbi;
        logic [7:0]                  reps;
    } stim_row_t;

    logic                        clk_dot4x;
    logic                        rst;
    logic                        phi_phase_start_dav;
    vic_cycle_pkg::cycle_type_e  cycle_type;
    vic_data_pkg::char_word_t    dbi;
    logic                        idle;
    logic                        aec;
    logic [2:0]                  sprite_cnt;
    logic [`VIC_NUM_SPRITES-1:0] sprite_dma;
    logic [`VIC_NUM_SPRITES-1:0] sprite_load;
    logic                        pixel_stb;
    logic [7:0]                  sprite_ptr [`VIC_NUM_SPRITES];
    logic [7:0]                  pixels_read;
    vic_data_pkg::char_word_t    char_read;
    vic_data_pkg::char_word_t    char_next;
    vic_data_pkg::sprite_pixel_t sprite_pixel;

    stim_row_t   stim_table [$];
    logic [15:0] lfsr_state;

    // reference model state
    vic_data_pkg::char_word_t    m_buf [`VIC_CHAR_BUF_DEPTH];
    int                          m_cnt;
    vic_data_pkg::char_word_t    m_next;
    vic_data_pkg::char_word_t    m_read;
    logic [7:0]                  m_pixels;
    logic [7:0]                  m_ptr [`VIC_NUM_SPRITES];
    logic [23:0]                 m_words [`VIC_NUM_SPRITES];
    logic [23:0]                 m_shift [`VIC_NUM_SPRITES];
    vic_data_pkg::sprite_pixel_t m_pixel;

    vic_fetch_top vic_fetch_top_i (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .phi_phase_start_dav (phi_phase_start_dav),
        .cycle_type          (cycle_type),
        .dbi                 (dbi),
        .idle                (idle),
        .aec                 (aec),
        .sprite_cnt          (sprite_cnt),
        .sprite_dma          (sprite_dma),
        .sprite_load         (sprite_load),
        .pixel_stb           (pixel_stb),
        .sprite_ptr          (sprite_ptr),
        .pixels_read         (pixels_read),
        .char_read           (char_read),
        .char_next           (char_next),
        .sprite_pixel        (sprite_pixel)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
    end

    // 16 bit galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [11:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[10:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error %0d ns: %s is %h, expected %h", $time, what, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // front-most sprite found by scanning up from sprite 0
    function automatic vic_data_pkg::sprite_pixel_t lowest_sprite(
        input logic [`VIC_NUM_SPRITES-1:0] bits);
        vic_data_pkg::sprite_pixel_t p;
        p = '0;
        for (int i = 0; i < `VIC_NUM_SPRITES; i++) begin
            if (bits[i] && !p.hit) begin
                p.hit   = 1'b1;
                p.index = 3'(i);
            end
        end
        return p;
    endfunction

    task automatic add_row(input vic_cycle_pkg::cycle_type_e ctype, input logic dav,
                           input logic a, input logic idl, input logic [2:0] cnt,
                           input logic [7:0] dma, input logic [7:0] load, input logic pix,
                           input logic rnd, input logic [11:0] bus, input logic [7:0] reps);
        stim_row_t r;
        r = {ctype, dav, a, idl, cnt, dma, load, pix, rnd, bus, reps};
        stim_table.push_back(r);
    endtask

    task automatic build_table();
        add_row(vic_cycle_pkg::cycle_li, 0, 1, 0, 3'd0, 8'h00, 8'h00, 0, 0, 12'h000, 2);
        // badline with the vic owning the bus
        add_row(vic_cycle_pkg::cycle_hgc, 1, 0, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 20);
        // counter holds without a strobe
        add_row(vic_cycle_pkg::cycle_hgc, 0, 0, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 1);
        // badline with aec high so the code reads 0xff
        add_row(vic_cycle_pkg::cycle_hrc, 1, 1, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 20);
        // g-access then idle then clear on refresh
        add_row(vic_cycle_pkg::cycle_lg, 1, 0, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 1);
        add_row(vic_cycle_pkg::cycle_lg, 1, 0, 1, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 1);
        add_row(vic_cycle_pkg::cycle_lr, 1, 0, 0, 3'd0, 8'h00, 8'h00, 0, 0, 12'h3c5, 1);
        add_row(vic_cycle_pkg::cycle_lg, 1, 1, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 1);
        // replay line of 41 words so position 0 comes round again
        add_row(vic_cycle_pkg::cycle_hrx, 1, 0, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 20);
        add_row(vic_cycle_pkg::cycle_lg, 1, 0, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 1);
        add_row(vic_cycle_pkg::cycle_hgi, 1, 0, 0, 3'd0, 8'h00, 8'h00, 0, 1, 12'h000, 21);
        // p-access for every sprite
        for (int c = 0; c < `VIC_NUM_SPRITES; c++) begin
            add_row(vic_cycle_pkg::cycle_lp, 1, 0, 0, 3'(c), SPRITE_DMA, 8'h00, 0, 1,
                    12'h000, 1);
        end
        // pointer holds while the cpu owns the bus
        add_row(vic_cycle_pkg::cycle_lp, 1, 1, 0, 3'd0, SPRITE_DMA, 8'h00, 0, 1, 12'h000, 1);
        // s-access with sprite 0 fixed so the others show through
        for (int c = 0; c < `VIC_NUM_SPRITES; c++) begin
            add_row(vic_cycle_pkg::cycle_hs1, 1, 0, 0, 3'(c), SPRITE_DMA, 8'h00, 0, c != 0,
                    12'h000, 1);
            add_row(vic_cycle_pkg::cycle_ls2, 1, 0, 0, 3'(c), SPRITE_DMA, 8'h00, 0, c != 0,
                    12'h00f, 1);
            add_row(vic_cycle_pkg::cycle_hs3, 1, 0, 0, 3'(c), SPRITE_DMA, 8'h00, 0, c != 0,
                    12'h000, 1);
        end
        add_row(vic_cycle_pkg::cycle_hs1, 1, 1, 0, 3'd2, SPRITE_DMA, 8'h00, 0, 1, 12'h000, 1);
        // load all shifters then shift past the end
        add_row(vic_cycle_pkg::cycle_li, 0, 1, 0, 3'd0, SPRITE_DMA, 8'hff, 0, 0, 12'h000, 1);
        add_row(vic_cycle_pkg::cycle_li, 0, 1, 0, 3'd0, SPRITE_DMA, 8'h00, 1, 0, 12'h000, 26);
        // load together with a shift
        add_row(vic_cycle_pkg::cycle_li, 0, 1, 0, 3'd0, SPRITE_DMA, 8'h04, 1, 0, 12'h000, 1);
        add_row(vic_cycle_pkg::cycle_li, 0, 1, 0, 3'd0, SPRITE_DMA, 8'h00, 1, 0, 12'h000, 3);
        add_row(vic_cycle_pkg::cycle_li, 0, 1, 0, 3'd0, 8'h00, 8'h00, 0, 0, 12'h000, 2);
    endtask

    task automatic model_reset();
        m_cnt    = 0;
        m_next   = '0;
        m_read   = '0;
        m_pixels = '0;
        m_pixel  = '0;
        for (int n = 0; n < `VIC_NUM_SPRITES; n++) begin
            m_ptr[n]   = '0;
            m_words[n] = '0;
            m_shift[n] = '0;
        end
    endtask

    // all registers move on the same edge so the model works from old values
    task automatic model_step(input stim_row_t r, input logic [11:0] bus);
        vic_data_pkg::char_word_t    fetch;
        vic_data_pkg::char_word_t    old_next;
        logic [23:0]                 old_words [`VIC_NUM_SPRITES];
        logic [`VIC_NUM_SPRITES-1:0] bits;
        logic                        c_new;
        logic                        c_old;
        logic                        s_acc;
        old_next = m_next;
        for (int n = 0; n < `VIC_NUM_SPRITES; n++) begin
            old_words[n] = m_words[n];
            bits[n]      = m_shift[n][23];
        end
        // priority sees the shifter bits from before this edge
        m_pixel = lowest_sprite(bits);
        for (int n = 0; n < `VIC_NUM_SPRITES; n++) begin
            if (r.load[n]) begin
                m_shift[n] = old_words[n];
            end else if (r.pix) begin
                m_shift[n] = m_shift[n] << 1;
            end
        end
        c_new = (r.ctype == vic_cycle_pkg::cycle_hrc) ||
                (r.ctype == vic_cycle_pkg::cycle_hgc);
        c_old = (r.ctype == vic_cycle_pkg::cycle_hrx) ||
                (r.ctype == vic_cycle_pkg::cycle_hgi);
        s_acc = (r.ctype == vic_cycle_pkg::cycle_hs1) ||
                (r.ctype == vic_cycle_pkg::cycle_ls2) ||
                (r.ctype == vic_cycle_pkg::cycle_hs3);
        fetch.colour = bus[11:8];
        fetch.code   = r.aec ? 8'hff : bus[7:0];
        if (r.dav) begin
            if (c_new) begin
                m_buf[m_cnt] = fetch;
                m_next       = fetch;
            end else if (c_old) begin
                m_next = m_buf[m_cnt];
            end
            if (c_new || c_old) begin
                m_cnt = (m_cnt + 1) % `VIC_CHAR_LINE_LEN;
            end
            if (!r.aec && r.ctype == vic_cycle_pkg::cycle_lg) begin
                m_pixels = bus[7:0];
                m_read   = r.idle ? '0 : old_next;
            end else if (!r.aec) begin
                m_pixels = '0;
            end
            // open bus reads 0xff without dma
            if (!r.aec && r.ctype == vic_cycle_pkg::cycle_lp) begin
                m_ptr[r.cnt] = r.dma[r.cnt] ? bus[7:0] : 8'hff;
            end
            if (!r.aec && s_acc && r.dma[r.cnt]) begin
                m_words[r.cnt] = {old_words[r.cnt][15:0], bus[7:0]};
            end
        end
    endtask

    task automatic compare_outputs();
        check_value("pixels_read", pixels_read, m_pixels);
        check_value("char_read", char_read, m_read);
        check_value("char_next", char_next, m_next);
        for (int n = 0; n < `VIC_NUM_SPRITES; n++) begin
            check_value($sformatf("sprite_ptr[%0d]", n), sprite_ptr[n], m_ptr[n]);
        end
        check_value("sprite_pixel", sprite_pixel, m_pixel);
    endtask

    // drive one row for one cycle and check after the edge
    task automatic apply_cycle(input stim_row_t r);
        logic [11:0] bus;
        bus = r.dbi;
        if (r.rnd) begin
            take_bits(12, bus);
        end
        phi_phase_start_dav = r.dav;
        cycle_type          = r.ctype;
        aec                 = r.aec;
        idle                = r.idle;
        sprite_cnt          = r.cnt;
        sprite_dma          = r.dma;
        sprite_load         = r.load;
        pixel_stb           = r.pix;
        dbi                 = bus;
        model_step(r, bus);
        @(posedge clk_dot4x);
        #(DRIVE_DELAY);
        compare_outputs();
    endtask

    initial begin
        rst                 = 1'b1;
        phi_phase_start_dav = 1'b0;
        cycle_type          = vic_cycle_pkg::cycle_li;
        dbi                 = '0;
        idle                = 1'b0;
        aec                 = 1'b1;
        sprite_cnt          = '0;
        sprite_dma          = '0;
        sprite_load         = '0;
        pixel_stb           = 1'b0;
        lfsr_state          = 16'd61545;
        build_table();
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_dot4x);
        #(DRIVE_DELAY);
        rst = 1'b0;
        foreach (stim_table[i]) begin
            repeat (stim_table[i].reps) begin
                apply_cycle(stim_table[i]);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // budget of 40 cycles per table row plus reset
    initial begin : watchdog
        int limit_cycles;
        #1;
        limit_cycles = stim_table.size() * 40 + RESET_CYCLES;
        repeat (limit_cycles) @(posedge clk_dot4x);
        $display("timeout: the test table did not finish within %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- Bender.yml
package:
  name: vic_fetch

export_include_dirs:
  - src

sources:
  - src/vic_cycle_pkg.sv
  - src/vic_data_pkg.sv
  - src/vic_bus_access.sv
  - src/vic_sprite_shifter.sv
  - src/vic_sprite_priority.sv
  - src/vic_fetch_top.sv
  - target: test
    files:
      - tests/tb_vic_fetch.sv

//--- vic_fetch_top.f
+incdir+src
src/vic_cycle_pkg.sv
src/vic_data_pkg.sv
src/vic_bus_access.sv
src/vic_sprite_shifter.sv
src/vic_sprite_priority.sv
src/vic_fetch_top.sv
tests/tb_vic_fetch.sv
